// File: core_pkg.sv
`default_nettype none

package core_pkg;

    // the reorder buffer depth must not exceed 2**TAG_W - 1, because tag 0 is reserved
    localparam int TAG_W = 3;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [TAG_W-1:0] tag_t;  // 0 means no pending producer
    typedef logic [4:0]       reg_idx_t;
    typedef logic [31:0]      word_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_word_u;

    typedef struct packed {
        logic     legal;
        alu_op_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        word_t    imm;  // already sign extended
    } decoded_t;

    typedef struct packed {
        logic    valid;
        tag_t    tag;
        alu_op_t op;
        word_t   a;
        word_t   b;
    } issue_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } result_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t rd;
        word_t    data;
    } commit_t;

endpackage

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  core_pkg::instr_word_u instr,
    output core_pkg::decoded_t    dec
);
    import core_pkg::*;

    always_comb begin
        dec = '0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                dec.rd    = instr.r_fmt.rd;
                dec.rs1   = instr.r_fmt.rs1;
                dec.rs2   = instr.r_fmt.rs2;
                dec.legal = 1'b1;
                case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
                    {7'b0000000, 3'b000}: dec.op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec.op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec.op = ALU_AND;
                    {7'b0000000, 3'b110}: dec.op = ALU_OR;
                    {7'b0000000, 3'b100}: dec.op = ALU_XOR;
                    default:              dec.legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // only ADDI, rs2 stays 0 so its lookup finds no producer
                dec.rd      = instr.i_fmt.rd;
                dec.rs1     = instr.i_fmt.rs1;
                dec.use_imm = 1'b1;
                dec.imm     = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
                dec.op      = ALU_ADD;
                dec.legal   = (instr.i_fmt.funct3 == 3'b000);
            end
            default: dec.legal = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: reg_status_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_status_file (
    input  wire                clk,
    input  wire                rst,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::word_t    val1,
    output core_pkg::word_t    val2,
    output core_pkg::tag_t     tag1,
    output core_pkg::tag_t     tag2,
    input  wire                set_tag,
    input  core_pkg::reg_idx_t set_rd,
    input  core_pkg::tag_t     set_num,
    input  core_pkg::commit_t  commit
);
    import core_pkg::*;

    word_t regs [32];
    tag_t  tags [32];

    // lookups see the state from before the edge
    always_comb begin
        if (rs1 == '0) begin
            val1 = '0;
            tag1 = '0;
        end else begin
            val1 = regs[rs1];
            tag1 = tags[rs1];
        end
        if (rs2 == '0) begin
            val2 = '0;
            tag2 = '0;
        end else begin
            val2 = regs[rs2];
            tag2 = tags[rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.data;
                if (tags[commit.rd] == commit.tag) begin
                    tags[commit.rd] <= '0;  // a younger producer keeps its tag
                end
            end
            // placed after the commit so a new rename of the same rd wins
            if (set_tag && set_rd != '0) begin
                tags[set_rd] <= set_num;
            end
        end
    end

endmodule

`default_nettype wire

// File: reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 7
) (
    input  wire                clk,
    input  wire                rst,
    input  wire                alloc,
    input  core_pkg::reg_idx_t alloc_rd,
    output core_pkg::tag_t     tail_tag,
    output logic               full,
    input  core_pkg::result_t  result,
    input  core_pkg::tag_t     q_tag1,
    input  core_pkg::tag_t     q_tag2,
    output logic               q_done1,
    output logic               q_done2,
    output core_pkg::word_t    q_data1,
    output core_pkg::word_t    q_data2,
    output core_pkg::commit_t  commit
);
    import core_pkg::*;

    word_t    data_q [1:ROB_DEPTH];
    reg_idx_t rd_q   [1:ROB_DEPTH];
    logic     done_q [1:ROB_DEPTH];
    tag_t     head_q;
    tag_t     tail_q;
    tag_t     count_q;
    logic     commit_fire;

    function automatic tag_t next_ptr(input tag_t p);
        return (p == tag_t'(ROB_DEPTH)) ? tag_t'(1) : p + tag_t'(1);
    endfunction

    function automatic logic in_range(input tag_t t);
        return (t != '0) && (t <= tag_t'(ROB_DEPTH));
    endfunction

    assign tail_tag = tail_q;
    assign full     = (count_q == tag_t'(ROB_DEPTH));

    assign commit_fire  = (count_q != '0) && done_q[head_q];
    assign commit.valid = commit_fire;
    assign commit.tag   = head_q;
    assign commit.rd    = rd_q[head_q];
    assign commit.data  = data_q[head_q];

    always_comb begin
        q_done1 = in_range(q_tag1) ? done_q[q_tag1] : 1'b0;
        q_done2 = in_range(q_tag2) ? done_q[q_tag2] : 1'b0;
        q_data1 = in_range(q_tag1) ? data_q[q_tag1] : '0;
        q_data2 = in_range(q_tag2) ? data_q[q_tag2] : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head_q  <= tag_t'(1);
            tail_q  <= tag_t'(1);
            count_q <= '0;
            for (int i = 1; i <= ROB_DEPTH; i++) begin
                done_q[i] <= 1'b0;
            end
        end else begin
            if (alloc) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= next_ptr(tail_q);
            end
            // result, alloc and commit always touch different entries
            if (result.valid) begin
                done_q[result.tag] <= 1'b1;
            end
            if (commit_fire) begin
                done_q[head_q] <= 1'b0;
                head_q         <= next_ptr(head_q);
            end
            case ({alloc, commit_fire})
                2'b10:   count_q <= count_q + tag_t'(1);
                2'b01:   count_q <= count_q - tag_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (result.valid) begin
            data_q[result.tag] <= result.data;
        end
    end

endmodule

`default_nettype wire

// File: alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire               clk,
    input  wire               rst,
    input  core_pkg::issue_t  issue,
    output core_pkg::result_t result
);
    import core_pkg::*;

    logic    s1_valid;
    tag_t    s1_tag;
    alu_op_t s1_op;
    word_t   s1_a;
    word_t   s1_b;
    logic    s2_valid;
    tag_t    s2_tag;
    word_t   s2_data;
    word_t   alu_out;

    always_comb begin
        case (s1_op)
            ALU_ADD: alu_out = s1_a + s1_b;
            ALU_SUB: alu_out = s1_a - s1_b;
            ALU_AND: alu_out = s1_a & s1_b;
            ALU_OR:  alu_out = s1_a | s1_b;
            ALU_XOR: alu_out = s1_a ^ s1_b;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag  <= issue.tag;
        s1_op   <= issue.op;
        s1_a    <= issue.a;
        s1_b    <= issue.b;
        s2_tag  <= s1_tag;  // the tag rides along with its operands
        s2_data <= alu_out;
    end

    assign result = '{valid: s2_valid, tag: s2_tag, data: s2_data};

endmodule

`default_nettype wire

// File: dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
    input  wire                clk,
    input  wire                rst,
    input  wire                instr_valid,
    output logic               instr_ready,
    input  core_pkg::decoded_t dec,
    input  core_pkg::tag_t     tag1,
    input  core_pkg::tag_t     tag2,
    input  core_pkg::word_t    val1,
    input  core_pkg::word_t    val2,
    input  wire                q_done1,
    input  wire                q_done2,
    input  core_pkg::word_t    q_data1,
    input  core_pkg::word_t    q_data2,
    input  wire                full,
    input  core_pkg::tag_t     tail_tag,
    output logic               alloc,
    output logic               set_tag,
    output core_pkg::issue_t   issue
);
    import core_pkg::*;

    logic    wait1;
    logic    wait2;
    word_t   op_a;
    word_t   op_b;
    logic    iss_valid;
    tag_t    iss_tag;
    alu_op_t iss_op;
    word_t   iss_a;
    word_t   iss_b;

    // an operand still in flight stalls the whole instruction
    assign wait1 = (tag1 != '0) && !q_done1;
    assign wait2 = !dec.use_imm && (tag2 != '0) && !q_done2;

    assign instr_ready = rst && !full && !(dec.legal && (wait1 || wait2));
    assign alloc       = instr_valid && instr_ready && dec.legal;  // illegal words are dropped
    assign set_tag     = alloc;

    assign op_a = (tag1 != '0) ? q_data1 : val1;
    assign op_b = dec.use_imm ? dec.imm : ((tag2 != '0) ? q_data2 : val2);

    always_ff @(posedge clk) begin
        if (!rst) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            iss_tag <= tail_tag;
            iss_op  <= dec.op;
            iss_a   <= op_a;
            iss_b   <= op_b;
        end
    end

    assign issue = '{valid: iss_valid, tag: iss_tag, op: iss_op, a: iss_a, b: iss_b};

endmodule

`default_nettype wire

// File: ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
    parameter int ROB_DEPTH = 7
) (
    input  wire               clk,
    input  wire               rst,
    input  wire               instr_valid,
    input  core_pkg::word_t   instr,
    output logic              instr_ready,
    output core_pkg::commit_t commit
);
    import core_pkg::*;

    decoded_t dec;
    word_t    val1;
    word_t    val2;
    tag_t     tag1;
    tag_t     tag2;
    logic     q_done1;
    logic     q_done2;
    word_t    q_data1;
    word_t    q_data2;
    logic     full;
    tag_t     tail_tag;
    logic     alloc;
    logic     set_tag;
    issue_t   issue;
    result_t  result;

    instr_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    dispatch_ctrl u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .dec         (dec),
        .tag1        (tag1),
        .tag2        (tag2),
        .val1        (val1),
        .val2        (val2),
        .q_done1     (q_done1),
        .q_done2     (q_done2),
        .q_data1     (q_data1),
        .q_data2     (q_data2),
        .full        (full),
        .tail_tag    (tail_tag),
        .alloc       (alloc),
        .set_tag     (set_tag),
        .issue       (issue)
    );

    reg_status_file u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .val1    (val1),
        .val2    (val2),
        .tag1    (tag1),
        .tag2    (tag2),
        .set_tag (set_tag),
        .set_rd  (dec.rd),
        .set_num (tail_tag),
        .commit  (commit)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk      (clk),
        .rst      (rst),
        .alloc    (alloc),
        .alloc_rd (dec.rd),
        .tail_tag (tail_tag),
        .full     (full),
        .result   (result),
        .q_tag1   (tag1),
        .q_tag2   (tag2),
        .q_done1  (q_done1),
        .q_done2  (q_done2),
        .q_data1  (q_data1),
        .q_data2  (q_data2),
        .commit   (commit)
    );

    alu_unit u_alu (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .result (result)
    );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // rst is active low and released on a rising edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import core_pkg::*;

    localparam int          ROB_DEPTH      = 3;
    localparam int          RESET_CYCLES   = 8;
    localparam int          NUM_INSTR      = 200;
    localparam int          NUM_DIRECTED   = 6;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR * 12;
    localparam logic [31:0] LFSR_SEED      = 32'h04d3e21e;

    localparam logic [2:0] K_ADD  = 3'd0;
    localparam logic [2:0] K_SUB  = 3'd1;
    localparam logic [2:0] K_AND  = 3'd2;
    localparam logic [2:0] K_OR   = 3'd3;
    localparam logic [2:0] K_XOR  = 3'd4;
    localparam logic [2:0] K_ADDI = 3'd5;

    typedef struct packed {
        logic        legal;
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
    } op_fields_t;

    typedef struct packed {
        tag_t        tag;
        logic [4:0]  rd;
        logic [31:0] data;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    commit_t     commit;

    logic [31:0] lfsr;
    op_fields_t  cur_op;
    logic [31:0] model_regs [32];
    expect_t     exp_q [$];
    tag_t        next_tag;
    logic        accept_seen;
    logic        rst_seen_high;
    int          cycle_count;
    int          error_count;
    int          accepted_count;
    int          legal_count;
    int          commit_count;

    tb_clock #(
        .PERIOD       (40),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    ooo_core_top #(
        .ROB_DEPTH (ROB_DEPTH)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .commit      (commit)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic op_fields_t make_op(input logic [2:0] kind, input int rd,
                                           input int rs1, input int rs2, input int imm);
        op_fields_t f;
        f.legal = 1'b1;
        f.kind  = kind;
        f.rd    = 5'(rd);
        f.rs1   = 5'(rs1);
        f.rs2   = 5'(rs2);
        f.imm   = 12'(imm);
        return f;
    endfunction

    // RV32I encodings of the supported operations
    function automatic logic [31:0] encode_word(input op_fields_t f);
        case (f.kind)
            K_ADD:   return {7'b0000000, f.rs2, f.rs1, 3'b000, f.rd, 7'b0110011};
            K_SUB:   return {7'b0100000, f.rs2, f.rs1, 3'b000, f.rd, 7'b0110011};
            K_AND:   return {7'b0000000, f.rs2, f.rs1, 3'b111, f.rd, 7'b0110011};
            K_OR:    return {7'b0000000, f.rs2, f.rs1, 3'b110, f.rd, 7'b0110011};
            K_XOR:   return {7'b0000000, f.rs2, f.rs1, 3'b100, f.rd, 7'b0110011};
            default: return {f.imm, f.rs1, 3'b000, f.rd, 7'b0010011};
        endcase
    endfunction

    // mul, slti, lw and a sub with a bad funct3
    function automatic logic [31:0] illegal_word(input logic [1:0] sel, input op_fields_t f);
        case (sel)
            2'd0:    return {7'b0000001, f.rs2, f.rs1, 3'b000, f.rd, 7'b0110011};
            2'd1:    return {f.imm, f.rs1, 3'b010, f.rd, 7'b0010011};
            2'd2:    return {f.imm, f.rs1, 3'b010, f.rd, 7'b0000011};
            default: return {7'b0100000, f.rs2, f.rs1, 3'b111, f.rd, 7'b0110011};
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input logic [2:0] kind,
                                                    input logic [31:0] a, input logic [31:0] b);
        case (kind)
            K_SUB:   return a - b;
            K_AND:   return a & b;
            K_OR:    return a | b;
            K_XOR:   return a ^ b;
            default: return a + b;  // add and addi
        endcase
    endfunction

    task automatic random_op(output op_fields_t f, output logic [31:0] w);
        logic [31:0] r;
        take_bits(4, r);
        f.legal = (r[3:0] != 4'd0);  // about one word in sixteen is illegal
        take_bits(3, r);
        f.kind = (r[2:0] > K_ADDI) ? K_ADDI : r[2:0];
        take_bits(3, r);
        f.rd = {2'b00, r[2:0]};
        take_bits(3, r);
        f.rs1 = {2'b00, r[2:0]};
        take_bits(3, r);
        f.rs2 = {2'b00, r[2:0]};
        take_bits(12, r);
        f.imm = r[11:0];
        if (f.legal) begin
            w = encode_word(f);
        end else begin
            take_bits(2, r);
            w = illegal_word(r[1:0], f);
        end
    endtask

    task automatic send_instr(input op_fields_t f, input logic [31:0] w);
        logic [31:0] gap;
        take_bits(2, gap);
        if (gap[1:0] == 2'b00) begin
            instr_valid <= 1'b0;
            @(posedge clk);
        end
        cur_op      <= f;
        instr       <= w;
        instr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!accept_seen);
    endtask

    task automatic check_commit();
        expect_t e;
        commit_count++;
        assert (exp_q.size() != 0) else begin
            error_count++;
            $display("commit of x%0d arrived with no instruction outstanding", commit.rd);
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (commit.tag == e.tag) else begin
                error_count++;
                $display("MISMATCH commit.tag: expected %h, got %h", e.tag, commit.tag);
            end
            assert (commit.rd == e.rd) else begin
                error_count++;
                $display("MISMATCH commit.rd: expected %h, got %h", e.rd, commit.rd);
            end
            assert (commit.data == e.data) else begin
                error_count++;
                $display("MISMATCH commit.data: expected %h, got %h", e.data, commit.data);
            end
        end
    endtask

    // the in-order architectural model is updated when the core accepts a word
    task automatic model_accept();
        logic [31:0] a;
        logic [31:0] b;
        expect_t     e;
        accepted_count++;
        if (cur_op.legal) begin
            legal_count++;
            a = model_regs[cur_op.rs1];
            if (cur_op.kind == K_ADDI) begin
                b = {{20{cur_op.imm[11]}}, cur_op.imm};
            end else begin
                b = model_regs[cur_op.rs2];
            end
            e.tag  = next_tag;
            e.rd   = cur_op.rd;
            e.data = expected_result(cur_op.kind, a, b);
            exp_q.push_back(e);
            // tags are handed out in program order and wrap after the last entry
            next_tag = (next_tag == tag_t'(ROB_DEPTH)) ? tag_t'(1) : next_tag + tag_t'(1);
            if (cur_op.rd != 5'd0) begin
                model_regs[cur_op.rd] = e.data;  // x0 stays zero in the model
            end
            assert (exp_q.size() <= ROB_DEPTH) else begin
                error_count++;
                $display("instruction accepted while the reorder buffer was full");
            end
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("accepted %0d, legal %0d, committed %0d, errors %0d",
                 accepted_count, legal_count, commit_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // outputs are stable here and hold the values the next rising edge samples
    always @(negedge clk) begin
        cycle_count++;
        accept_seen = instr_valid && instr_ready;
        if (!rst) begin
            assert (!commit.valid) else begin
                error_count++;
                $display("MISMATCH commit.valid: expected %h, got %h", 1'b0, commit.valid);
            end
            assert (!instr_ready) else begin
                error_count++;
                $display("MISMATCH instr_ready: expected %h, got %h", 1'b0, instr_ready);
            end
        end else begin
            if (!rst_seen_high) begin
                assert (!commit.valid) else begin
                    error_count++;
                    $display("MISMATCH commit.valid: expected %h, got %h", 1'b0, commit.valid);
                end
            end
            if (commit.valid) begin
                check_commit();
            end
            if (accept_seen) begin
                model_accept();
            end
        end
        rst_seen_high = rst;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run(1'b1);
    end

    initial begin
        op_fields_t  f;
        logic [31:0] w;
        instr_valid    = 1'b0;
        instr          = '0;
        cur_op         = '0;
        lfsr           = LFSR_SEED;
        next_tag       = tag_t'(1);
        accept_seen    = 1'b0;
        rst_seen_high  = 1'b0;
        cycle_count    = 0;
        error_count    = 0;
        accepted_count = 0;
        legal_count    = 0;
        commit_count   = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end

        @(posedge clk);
        while (!rst) @(posedge clk);

        // a dependent chain through x1 to x3, then a write to x0 and a read of it
        send_instr(make_op(K_ADDI, 1, 0, 0, 5), encode_word(make_op(K_ADDI, 1, 0, 0, 5)));
        send_instr(make_op(K_ADD, 2, 1, 1, 0), encode_word(make_op(K_ADD, 2, 1, 1, 0)));
        send_instr(make_op(K_SUB, 3, 2, 1, 0), encode_word(make_op(K_SUB, 3, 2, 1, 0)));
        send_instr(make_op(K_XOR, 1, 3, 2, 0), encode_word(make_op(K_XOR, 1, 3, 2, 0)));
        send_instr(make_op(K_ADDI, 0, 1, 0, 7), encode_word(make_op(K_ADDI, 0, 1, 0, 7)));
        send_instr(make_op(K_OR, 4, 0, 1, 0), encode_word(make_op(K_OR, 4, 0, 1, 0)));

        for (int n = NUM_DIRECTED; n < NUM_INSTR; n++) begin
            random_op(f, w);
            send_instr(f, w);
        end
        instr_valid <= 1'b0;

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // room for a stray commit to show up

        assert (commit_count == legal_count) else begin
            error_count++;
            $display("MISMATCH commit count: expected %h, got %h", legal_count, commit_count);
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// File: project.f
core_pkg.sv
instr_decoder.sv
reg_status_file.sv
reorder_buffer.sv
alu_unit.sv
dispatch_ctrl.sv
ooo_core_top.sv
tb_clock.sv
tb_ooo_core.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - core_pkg.sv
      - instr_decoder.sv
      - reg_status_file.sv
      - reorder_buffer.sv
      - alu_unit.sv
      - dispatch_ctrl.sv
      - ooo_core_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_ooo_core.sv
